// ==== logic/l2_cache_defines.svh ====
`ifndef L2_CACHE_DEFINES_SVH
`define L2_CACHE_DEFINES_SVH

// Cache geometry
`define L2_SETS        128
`define L2_WAYS        4
`define L2_LINE_BEATS  8

// Sets cleared by the sweep after reset
`define L2_INIT_SETS   `L2_SETS

// Top bit index of the DDR beat address
`define L2_ADDR_BITS   24

// Bus widths
`define L2_CPU_ADDR    30
`define L2_CPU_WORD    32
`define L2_DDR_BEAT    64

`endif

// ==== logic/l2_cache_pkg.sv ====
`default_nettype none

`include "l2_cache_defines.svh"

package l2_cache_pkg;

	// CPU bus
	typedef logic [`L2_CPU_ADDR-1:0]     cpu_addr_t;
	typedef logic [`L2_CPU_WORD-1:0]     cpu_data_t;
	typedef logic [`L2_CPU_WORD/8-1:0]   cpu_be_t;
	typedef logic [3:0]                  burst_t;

	// DDR bus
	typedef logic [`L2_ADDR_BITS:0]      ddr_addr_t;
	typedef logic [`L2_DDR_BEAT-1:0]     ddr_data_t;
	typedef logic [`L2_DDR_BEAT/8-1:0]   ddr_be_t;
	typedef logic [7:0]                  ddr_burst_t;

	// Cache organisation
	typedef logic [$clog2(`L2_SETS)-1:0]       set_idx_t;
	typedef logic [$clog2(`L2_LINE_BEATS)-1:0] beat_idx_t;
	typedef logic [`L2_ADDR_BITS-$clog2(`L2_SETS)-$clog2(`L2_LINE_BEATS):0] tag_t;
	typedef logic [$clog2(`L2_WAYS)-1:0]       way_idx_t;
	typedef logic [`L2_WAYS-1:0]               way_mask_t;
	typedef logic [$clog2(`L2_WAYS)-1:0]       lru_age_t;

	typedef enum logic [2:0] {
		INIT, IDLE, WRITE_ONE, READ_ONE, FILL, TAG_WRITE
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/way_access_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface way_access_if;

	// Lookup address
	l2_cache_pkg::set_idx_t  set;
	l2_cache_pkg::tag_t      tag;
	l2_cache_pkg::beat_idx_t beat;
	logic                    half;

	// Line fill with one beat per strobe
	logic                    fill_we;
	l2_cache_pkg::way_idx_t  fill_way;
	l2_cache_pkg::beat_idx_t fill_beat;
	l2_cache_pkg::ddr_data_t fill_data;
	logic                    tag_we;

	// Write hit
	logic                    upd_we;
	l2_cache_pkg::ddr_data_t upd_data;
	l2_cache_pkg::ddr_be_t   upd_be;

	logic                    inv_we;

	logic                    hit;
	l2_cache_pkg::way_idx_t  hit_way;
	l2_cache_pkg::cpu_data_t rd_data;

	modport ctrl (
		output set, tag, beat, half,
		output fill_we, fill_way, fill_beat, fill_data, tag_we,
		output upd_we, upd_data, upd_be, inv_we,
		input  hit, hit_way
	);

	modport ways (
		input  set, tag, beat, half,
		input  fill_we, fill_way, fill_beat, fill_data, tag_we,
		input  upd_we, upd_data, upd_be, inv_we,
		output hit, hit_way, rd_data
	);

endinterface

`default_nettype wire

// ==== logic/lru_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface lru_if;

	l2_cache_pkg::set_idx_t set;
	logic                   touch;
	l2_cache_pkg::way_idx_t touch_way;

	// Way holding the oldest age of the set
	l2_cache_pkg::way_idx_t victim;

	modport ctrl (
		output set, touch, touch_way,
		input  victim
	);

	modport lru (
		input  set, touch, touch_way,
		output victim
	);

endinterface

`default_nettype wire

// ==== logic/cache_ways.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_defines.svh"

module cache_ways (
	input  logic                    CLK,
	way_access_if.ways              way,
	output l2_cache_pkg::cpu_data_t CPU_DOUT
);

	localparam int LINE_WORDS = `L2_SETS * `L2_LINE_BEATS;
	localparam int IDX_BITS   = $clog2(LINE_WORDS);

	l2_cache_pkg::way_mask_t valid [`L2_SETS];
	l2_cache_pkg::tag_t      tags  [`L2_WAYS][`L2_SETS];
	l2_cache_pkg::ddr_data_t lines [`L2_WAYS][LINE_WORDS];

	l2_cache_pkg::way_mask_t hit_vec;
	l2_cache_pkg::ddr_data_t rd_beat;
	logic [IDX_BITS-1:0]     rd_idx;
	logic [IDX_BITS-1:0]     wr_idx;
	logic                    wr_en;
	l2_cache_pkg::way_idx_t  wr_way;
	l2_cache_pkg::ddr_data_t wr_data;
	l2_cache_pkg::ddr_be_t   wr_be;

	always_comb begin
		hit_vec     = '0;
		way.hit_way = '0;
		for (int w = 0; w < `L2_WAYS; w++) begin
			hit_vec[w] = valid[way.set][w] && (tags[w][way.set] == way.tag);
			if (hit_vec[w]) begin
				way.hit_way = l2_cache_pkg::way_idx_t'(w);
			end
		end
	end

	assign way.hit = |hit_vec;

	assign rd_idx      = {way.set, way.beat};
	assign rd_beat     = lines[way.hit_way][rd_idx];
	assign way.rd_data = way.half ? rd_beat[`L2_DDR_BEAT-1:`L2_CPU_WORD]
		: rd_beat[`L2_CPU_WORD-1:0];

	// Fill beats take priority over a write hit
	assign wr_en   = way.fill_we || way.upd_we;
	assign wr_way  = way.fill_we ? way.fill_way : way.hit_way;
	assign wr_idx  = {way.set, (way.fill_we ? way.fill_beat : way.beat)};
	assign wr_data = way.fill_we ? way.fill_data : way.upd_data;
	assign wr_be   = way.fill_we ? '1 : way.upd_be;

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			for (int b = 0; b < $bits(l2_cache_pkg::ddr_be_t); b++) begin
				if (wr_be[b]) begin
					lines[wr_way][wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
				end
			end
		end
		if (way.tag_we) begin
			tags[way.fill_way][way.set] <= way.tag;
		end
	end

	always_ff @(posedge CLK) begin
		if (way.inv_we) begin
			valid[way.set] <= '0;
		end else if (way.tag_we) begin
			valid[way.set][way.fill_way] <= 1'b1;
		end
	end

	// Word of the current lookup that goes out with the ready strobe
	always_ff @(posedge CLK) begin
		CPU_DOUT <= way.rd_data;
	end

	// A line is only ever fetched into one way of its set
	assert property (@(posedge CLK) !$isunknown(hit_vec) |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== logic/lru_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_defines.svh"

module lru_tracker (
	input logic CLK,
	lru_if.lru  lru
);

	l2_cache_pkg::lru_age_t  ages [`L2_SETS][`L2_WAYS];
	l2_cache_pkg::lru_age_t  touched_age;
	l2_cache_pkg::way_mask_t age_seen;

	// Power-up ages follow the way number
	initial begin
		for (int s = 0; s < `L2_SETS; s++) begin
			for (int w = 0; w < `L2_WAYS; w++) begin
				ages[s][w] = l2_cache_pkg::lru_age_t'(w);
			end
		end
	end

	always_comb begin
		lru.victim  = '0;
		age_seen    = '0;
		touched_age = ages[lru.set][lru.touch_way];
		for (int w = 0; w < `L2_WAYS; w++) begin
			if (ages[lru.set][w] == '1) begin
				lru.victim = l2_cache_pkg::way_idx_t'(w);
			end
			age_seen[ages[lru.set][w]] = 1'b1;
		end
	end

	always @(posedge CLK) begin
		if (lru.touch) begin
			for (int w = 0; w < `L2_WAYS; w++) begin
				if (l2_cache_pkg::way_idx_t'(w) == lru.touch_way) begin
					ages[lru.set][w] <= '0;
				end else if (ages[lru.set][w] < touched_age) begin
					ages[lru.set][w] <= ages[lru.set][w] + 1'b1;
				end
			end
		end
	end

	// Touches keep every age of a set distinct
	assert property (@(posedge CLK) !$isunknown(lru.set) |-> &age_seen);

endmodule

`default_nettype wire

// ==== logic/cache_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_defines.svh"

module cache_controller (
	input  logic                     CLK,
	input  logic                     rst,
	input  l2_cache_pkg::cpu_addr_t  CPU_ADDR,
	input  l2_cache_pkg::cpu_data_t  CPU_DIN,
	output logic                     CPU_DOUT_READY,
	input  l2_cache_pkg::cpu_be_t    CPU_BE,
	input  l2_cache_pkg::burst_t     CPU_BURSTCNT,
	output logic                     CPU_BUSY,
	input  logic                     CPU_RD,
	input  logic                     CPU_WE,
	output l2_cache_pkg::ddr_addr_t  DDRAM_ADDR,
	output l2_cache_pkg::ddr_data_t  DDRAM_DIN,
	input  l2_cache_pkg::ddr_data_t  DDRAM_DOUT,
	input  logic                     DDRAM_DOUT_READY,
	output l2_cache_pkg::ddr_be_t    DDRAM_BE,
	output l2_cache_pkg::ddr_burst_t DDRAM_BURSTCNT,
	input  logic                     DDRAM_BUSY,
	output logic                     DDRAM_RD,
	output logic                     DDRAM_WE,
	way_access_if.ctrl               way,
	lru_if.ctrl                      lru
);

	localparam int BEAT_BITS = $clog2(`L2_LINE_BEATS);
	localparam int SET_BITS  = $clog2(`L2_SETS);

	l2_cache_pkg::ctrl_state_t state;
	l2_cache_pkg::set_idx_t    sweep;
	l2_cache_pkg::set_idx_t    look_set;
	l2_cache_pkg::ddr_addr_t   addr;
	logic                      half;
	l2_cache_pkg::burst_t      burst_left;
	l2_cache_pkg::cpu_data_t   din;
	l2_cache_pkg::cpu_be_t     be;
	l2_cache_pkg::ddr_be_t     be64;
	l2_cache_pkg::beat_idx_t   fill_cnt;
	l2_cache_pkg::way_idx_t    victim;
	logic                      dout_ready;
	logic                      ddr_rd;
	logic                      ddr_we;

	// Byte lanes of the addressed 32-bit half
	assign be64 = half ? {be, l2_cache_pkg::cpu_be_t'(0)} : {l2_cache_pkg::cpu_be_t'(0), be};

	assign look_set = (state == l2_cache_pkg::INIT) ? sweep
		: l2_cache_pkg::set_idx_t'(addr >> BEAT_BITS);

	assign way.set       = look_set;
	assign way.tag       = l2_cache_pkg::tag_t'(addr >> (BEAT_BITS + SET_BITS));
	assign way.beat      = l2_cache_pkg::beat_idx_t'(addr);
	assign way.half      = half;
	assign way.fill_we   = (state == l2_cache_pkg::FILL) && DDRAM_DOUT_READY;
	assign way.fill_way  = victim;
	assign way.fill_beat = fill_cnt;
	assign way.fill_data = DDRAM_DOUT;
	assign way.tag_we    = (state == l2_cache_pkg::TAG_WRITE);
	assign way.upd_we    = (state == l2_cache_pkg::WRITE_ONE) && way.hit && !DDRAM_BUSY;
	assign way.upd_data  = {din, din};
	assign way.upd_be    = be64;
	assign way.inv_we    = (state == l2_cache_pkg::INIT);

	assign lru.set       = look_set;
	assign lru.touch     = (state == l2_cache_pkg::READ_ONE) && way.hit;
	assign lru.touch_way = way.hit_way;

	// Reads always fetch the whole aligned line
	assign DDRAM_ADDR     = ddr_rd
		? (addr & ~l2_cache_pkg::ddr_addr_t'(`L2_LINE_BEATS - 1)) : addr;
	assign DDRAM_DIN      = {din, din};
	assign DDRAM_BE       = be64;
	assign DDRAM_BURSTCNT = ddr_rd ? l2_cache_pkg::ddr_burst_t'(`L2_LINE_BEATS)
		: l2_cache_pkg::ddr_burst_t'(1);
	assign DDRAM_RD       = ddr_rd;
	assign DDRAM_WE       = ddr_we;

	assign CPU_BUSY       = (state != l2_cache_pkg::IDLE);
	assign CPU_DOUT_READY = dout_ready;

	always_ff @(posedge CLK) begin
		dout_ready <= 1'b0;
		if (!DDRAM_BUSY) begin
			ddr_rd <= 1'b0;
			ddr_we <= 1'b0;
		end

		if (rst) begin
			state  <= l2_cache_pkg::INIT;
			sweep  <= '0;
			ddr_rd <= 1'b0;
			ddr_we <= 1'b0;
		end else begin
			case (state)
				l2_cache_pkg::INIT: begin
					sweep <= sweep + 1'b1;
					if (sweep == l2_cache_pkg::set_idx_t'(`L2_INIT_SETS - 1)) begin
						state <= l2_cache_pkg::IDLE;
					end
				end

				l2_cache_pkg::IDLE: begin
					if (CPU_RD || CPU_WE) begin
						addr       <= l2_cache_pkg::ddr_addr_t'(CPU_ADDR >> 1);
						half       <= CPU_ADDR[0];
						burst_left <= CPU_BURSTCNT;
						din        <= CPU_DIN;
						be         <= CPU_BE;
					end
					if (CPU_RD) begin
						state <= l2_cache_pkg::READ_ONE;
					end else if (CPU_WE) begin
						ddr_we <= 1'b1;
						state  <= l2_cache_pkg::WRITE_ONE;
					end
				end

				l2_cache_pkg::WRITE_ONE: begin
					if (!DDRAM_BUSY) begin
						state <= l2_cache_pkg::IDLE;
					end
				end

				l2_cache_pkg::READ_ONE: begin
					if (way.hit) begin
						dout_ready <= 1'b1;
						half       <= ~half;
						burst_left <= burst_left - 1'b1;
						if (half) begin
							addr <= addr + 1'b1;
						end
						if (burst_left <= 1) begin
							state <= l2_cache_pkg::IDLE;
						end
					end else begin
						victim   <= lru.victim;
						fill_cnt <= '0;
						ddr_rd   <= 1'b1;
						state    <= l2_cache_pkg::FILL;
					end
				end

				l2_cache_pkg::FILL: begin
					if (DDRAM_DOUT_READY) begin
						fill_cnt <= fill_cnt + 1'b1;
						if (fill_cnt == l2_cache_pkg::beat_idx_t'(`L2_LINE_BEATS - 1)) begin
							state <= l2_cache_pkg::TAG_WRITE;
						end
					end
				end

				l2_cache_pkg::TAG_WRITE: begin
					state <= l2_cache_pkg::READ_ONE;
				end

				default: begin
					state <= l2_cache_pkg::INIT;
				end
			endcase
		end
	end

	// DDR returns beats only for a line fill that is in progress
	assert property (@(posedge CLK) disable iff (rst)
		DDRAM_DOUT_READY |-> state == l2_cache_pkg::FILL);

	assert property (@(posedge CLK) disable iff (rst)
		(DDRAM_RD || DDRAM_WE) && DDRAM_BUSY |=>
		$stable({DDRAM_RD, DDRAM_WE, DDRAM_ADDR, DDRAM_DIN, DDRAM_BE, DDRAM_BURSTCNT}));

	assert property (@(posedge CLK) disable iff (rst)
		CPU_BUSY |-> !(CPU_RD || CPU_WE));

endmodule

`default_nettype wire

// ==== logic/l2_cache.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_cache (
	input  logic                     CLK,
	input  logic                     rst,

	// 32-bit CPU bus
	input  l2_cache_pkg::cpu_addr_t  CPU_ADDR,
	input  l2_cache_pkg::cpu_data_t  CPU_DIN,
	output l2_cache_pkg::cpu_data_t  CPU_DOUT,
	output logic                     CPU_DOUT_READY,
	input  l2_cache_pkg::cpu_be_t    CPU_BE,
	input  l2_cache_pkg::burst_t     CPU_BURSTCNT,
	output logic                     CPU_BUSY,
	input  logic                     CPU_RD,
	input  logic                     CPU_WE,

	// 64-bit DDR bus
	output l2_cache_pkg::ddr_addr_t  DDRAM_ADDR,
	output l2_cache_pkg::ddr_data_t  DDRAM_DIN,
	input  l2_cache_pkg::ddr_data_t  DDRAM_DOUT,
	input  logic                     DDRAM_DOUT_READY,
	output l2_cache_pkg::ddr_be_t    DDRAM_BE,
	output l2_cache_pkg::ddr_burst_t DDRAM_BURSTCNT,
	input  logic                     DDRAM_BUSY,
	output logic                     DDRAM_RD,
	output logic                     DDRAM_WE
);

	way_access_if way_bus ();
	lru_if        lru_bus ();

	cache_controller i_ctrl (
		.CLK              (CLK),
		.rst              (rst),
		.CPU_ADDR         (CPU_ADDR),
		.CPU_DIN          (CPU_DIN),
		.CPU_DOUT_READY   (CPU_DOUT_READY),
		.CPU_BE           (CPU_BE),
		.CPU_BURSTCNT     (CPU_BURSTCNT),
		.CPU_BUSY         (CPU_BUSY),
		.CPU_RD           (CPU_RD),
		.CPU_WE           (CPU_WE),
		.DDRAM_ADDR       (DDRAM_ADDR),
		.DDRAM_DIN        (DDRAM_DIN),
		.DDRAM_DOUT       (DDRAM_DOUT),
		.DDRAM_DOUT_READY (DDRAM_DOUT_READY),
		.DDRAM_BE         (DDRAM_BE),
		.DDRAM_BURSTCNT   (DDRAM_BURSTCNT),
		.DDRAM_BUSY       (DDRAM_BUSY),
		.DDRAM_RD         (DDRAM_RD),
		.DDRAM_WE         (DDRAM_WE),
		.way              (way_bus.ctrl),
		.lru              (lru_bus.ctrl)
	);

	cache_ways i_ways (
		.CLK      (CLK),
		.way      (way_bus.ways),
		.CPU_DOUT (CPU_DOUT)
	);

	lru_tracker i_lru (
		.CLK (CLK),
		.lru (lru_bus.lru)
	);

endmodule

`default_nettype wire

// ==== dv/ddr_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr_model (
	input  logic                     CLK,
	input  logic                     rst,
	input  l2_cache_pkg::ddr_addr_t  DDRAM_ADDR,
	input  l2_cache_pkg::ddr_data_t  DDRAM_DIN,
	output l2_cache_pkg::ddr_data_t  DDRAM_DOUT,
	output logic                     DDRAM_DOUT_READY,
	input  l2_cache_pkg::ddr_be_t    DDRAM_BE,
	input  l2_cache_pkg::ddr_burst_t DDRAM_BURSTCNT,
	output logic                     DDRAM_BUSY,
	input  logic                     DDRAM_RD,
	input  logic                     DDRAM_WE
);

	// Sparse memory whose beats get random contents when first touched
	l2_cache_pkg::ddr_data_t mem [l2_cache_pkg::ddr_addr_t];

	l2_cache_pkg::ddr_addr_t  rd_addr;
	l2_cache_pkg::ddr_burst_t last_rd_burst;
	l2_cache_pkg::ddr_burst_t beats_left = '0;
	l2_cache_pkg::ddr_burst_t beat_idx = '0;
	l2_cache_pkg::ddr_addr_t  last_wr_addr;
	l2_cache_pkg::ddr_be_t    last_wr_be;
	l2_cache_pkg::ddr_burst_t last_wr_burst;
	int                       rd_count = 0;
	int                       wr_count = 0;

	function automatic l2_cache_pkg::ddr_data_t peek(l2_cache_pkg::ddr_addr_t a);
		if (!mem.exists(a)) begin
			mem[a] = {$urandom, $urandom};
		end
		return mem[a];
	endfunction

	function automatic void store(l2_cache_pkg::ddr_addr_t a, l2_cache_pkg::ddr_data_t d,
		l2_cache_pkg::ddr_be_t be);
		l2_cache_pkg::ddr_data_t beat;
		beat = peek(a);
		for (int b = 0; b < 8; b++) begin
			if (be[b]) begin
				beat[b*8 +: 8] = d[b*8 +: 8];
			end
		end
		mem[a] = beat;
	endfunction

	initial begin
		DDRAM_BUSY       = 1'b0;
		DDRAM_DOUT_READY = 1'b0;
		DDRAM_DOUT       = '0;
	end

	always @(posedge CLK) begin
		if (rst) begin
			beats_left <= '0;
		end else begin
			if (DDRAM_DOUT_READY) begin
				beat_idx   <= beat_idx + 1'b1;
				beats_left <= beats_left - 1'b1;
			end
			if (DDRAM_RD && !DDRAM_BUSY) begin
				rd_addr       <= DDRAM_ADDR;
				beat_idx      <= '0;
				beats_left    <= DDRAM_BURSTCNT;
				last_rd_burst <= DDRAM_BURSTCNT;
				rd_count      <= rd_count + 1;
			end
			if (DDRAM_WE && !DDRAM_BUSY) begin
				store(DDRAM_ADDR, DDRAM_DIN, DDRAM_BE);
				last_wr_addr  <= DDRAM_ADDR;
				last_wr_be    <= DDRAM_BE;
				last_wr_burst <= DDRAM_BURSTCNT;
				wr_count      <= wr_count + 1;
			end
		end
	end

	// Random busy cycles and gaps between read beats
	always @(negedge CLK) begin
		DDRAM_BUSY       <= ($urandom_range(3) == 0);
		DDRAM_DOUT_READY <= (beats_left != 0) && ($urandom_range(2) != 0);
		if (beats_left != 0) begin
			DDRAM_DOUT <= peek(l2_cache_pkg::ddr_addr_t'(rd_addr + beat_idx));
		end
	end

endmodule

`default_nettype wire

// ==== dv/l2_cache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_cache_tb;

	// Far above the length of the whole test sequence
	localparam int TIMEOUT_CYCLES = 20000;

	logic                     CLK = 1'b0;
	logic                     rst;
	l2_cache_pkg::cpu_addr_t  CPU_ADDR;
	l2_cache_pkg::cpu_data_t  CPU_DIN;
	l2_cache_pkg::cpu_data_t  CPU_DOUT;
	logic                     CPU_DOUT_READY;
	l2_cache_pkg::cpu_be_t    CPU_BE;
	l2_cache_pkg::burst_t     CPU_BURSTCNT;
	logic                     CPU_BUSY;
	logic                     CPU_RD;
	logic                     CPU_WE;
	l2_cache_pkg::ddr_addr_t  DDRAM_ADDR;
	l2_cache_pkg::ddr_data_t  DDRAM_DIN;
	l2_cache_pkg::ddr_data_t  DDRAM_DOUT;
	logic                     DDRAM_DOUT_READY;
	l2_cache_pkg::ddr_be_t    DDRAM_BE;
	l2_cache_pkg::ddr_burst_t DDRAM_BURSTCNT;
	logic                     DDRAM_BUSY;
	logic                     DDRAM_RD;
	logic                     DDRAM_WE;

	int errors = 0;
	int cycles = 0;

	l2_cache i_dut (.*);

	ddr_model i_ddr (.*);

	always #10 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still busy after %0d cycles, %0d errors", cycles, errors);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic check_data(string name, l2_cache_pkg::cpu_data_t got,
		l2_cache_pkg::cpu_data_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(string name, l2_cache_pkg::ddr_addr_t got,
		l2_cache_pkg::ddr_addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_be(string name, l2_cache_pkg::ddr_be_t got,
		l2_cache_pkg::ddr_be_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp) begin
			errors++;
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// CPU word address of a word inside the line of a tag and set
	function automatic l2_cache_pkg::cpu_addr_t word_addr(int tag, int set, int word);
		return l2_cache_pkg::cpu_addr_t'((tag << 11) | (set << 4) | word);
	endfunction

	function automatic l2_cache_pkg::cpu_data_t model_word(l2_cache_pkg::cpu_addr_t a);
		l2_cache_pkg::ddr_data_t beat;
		beat = i_ddr.peek(l2_cache_pkg::ddr_addr_t'(a >> 1));
		return a[0] ? beat[63:32] : beat[31:0];
	endfunction

	function automatic l2_cache_pkg::cpu_data_t merge_bytes(l2_cache_pkg::cpu_data_t old,
		l2_cache_pkg::cpu_data_t data, l2_cache_pkg::cpu_be_t be);
		l2_cache_pkg::cpu_data_t word;
		word = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				word[b*8 +: 8] = data[b*8 +: 8];
			end
		end
		return word;
	endfunction

	// Issues a read burst and checks every word, the latency of a hit and the DDR reads
	task automatic read_burst(l2_cache_pkg::cpu_addr_t a, l2_cache_pkg::burst_t n, logic miss);
		int reads;
		int got;
		int wait_cycles;
		reads       = i_ddr.rd_count;
		got         = 0;
		wait_cycles = 0;
		CPU_ADDR     = a;
		CPU_BURSTCNT = n;
		CPU_RD       = 1'b1;
		while (got < n) begin
			@(negedge CLK);
			CPU_RD = 1'b0;
			wait_cycles++;
			if (CPU_DOUT_READY) begin
				if (got == 0 && !miss) begin
					check_count("first word latency", wait_cycles, 2);
				end
				check_data("CPU_DOUT", CPU_DOUT,
					model_word(l2_cache_pkg::cpu_addr_t'(a + got)));
				got++;
			end
		end
		check_flag("CPU_BUSY", CPU_BUSY, 1'b0);
		check_count("DDR reads", i_ddr.rd_count - reads, miss ? 1 : 0);
		if (miss) begin
			check_addr("DDRAM_ADDR", i_ddr.rd_addr,
				l2_cache_pkg::ddr_addr_t'(a >> 1) & ~l2_cache_pkg::ddr_addr_t'(7));
			check_count("DDRAM_BURSTCNT", int'(i_ddr.last_rd_burst), 8);
		end
	endtask

	task automatic write_word(l2_cache_pkg::cpu_addr_t a, l2_cache_pkg::cpu_data_t data,
		l2_cache_pkg::cpu_be_t be);
		int writes;
		writes   = i_ddr.wr_count;
		CPU_ADDR = a;
		CPU_DIN  = data;
		CPU_BE   = be;
		CPU_WE   = 1'b1;
		@(negedge CLK);
		CPU_WE = 1'b0;
		while (CPU_BUSY) begin
			@(negedge CLK);
		end
		check_count("DDR writes", i_ddr.wr_count - writes, 1);
		check_addr("DDRAM_ADDR", i_ddr.last_wr_addr, l2_cache_pkg::ddr_addr_t'(a >> 1));
		check_be("DDRAM_BE", i_ddr.last_wr_be, a[0] ? {be, 4'h0} : {4'h0, be});
		check_count("DDRAM_BURSTCNT", int'(i_ddr.last_wr_burst), 1);
	endtask

	task automatic write_and_verify(l2_cache_pkg::cpu_addr_t a, l2_cache_pkg::cpu_data_t data,
		l2_cache_pkg::cpu_be_t be);
		l2_cache_pkg::cpu_data_t merged;
		merged = merge_bytes(model_word(a), data, be);
		write_word(a, data, be);
		check_data("DDR memory word", model_word(a), merged);
		read_burst(a, 1, 1'b0);
	endtask

	task automatic reset_sweep();
		rst = 1'b1;
		repeat (10) begin
			@(negedge CLK);
			check_flag("CPU_DOUT_READY", CPU_DOUT_READY, 1'b0);
		end
		rst = 1'b0;
		@(negedge CLK);
		check_flag("CPU_BUSY", CPU_BUSY, 1'b1);
		while (CPU_BUSY) begin
			check_flag("CPU_DOUT_READY", CPU_DOUT_READY, 1'b0);
			check_flag("DDRAM_RD", DDRAM_RD, 1'b0);
			check_flag("DDRAM_WE", DDRAM_WE, 1'b0);
			@(negedge CLK);
		end
		check_count("DDR commands after reset", i_ddr.rd_count + i_ddr.wr_count, 0);
	endtask

	task automatic read_miss();
		read_burst(word_addr(3, 1, 5), 1, 1'b1);
	endtask

	task automatic read_hit();
		read_burst(word_addr(3, 1, 5), 1, 1'b0);
		read_burst(word_addr(3, 1, 1), 15, 1'b0);
	endtask

	task automatic write_through();
		write_and_verify(word_addr(3, 1, 6), 32'hA5C3_5AF0, 4'b0110);
		write_and_verify(word_addr(3, 1, 9), 32'h1E2D_3C4B, 4'b1001);
	endtask

	// Tags 8 to 12 share set 5 and tag 8 is touched again before tag 12 arrives
	task automatic lru_replace();
		read_burst(word_addr(8, 5, 2), 1, 1'b1);
		read_burst(word_addr(9, 5, 2), 1, 1'b1);
		read_burst(word_addr(10, 5, 2), 1, 1'b1);
		read_burst(word_addr(11, 5, 2), 1, 1'b1);
		read_burst(word_addr(8, 5, 3), 1, 1'b0);
		read_burst(word_addr(12, 5, 2), 1, 1'b1);
		read_burst(word_addr(8, 5, 4), 1, 1'b0);
		read_burst(word_addr(9, 5, 2), 1, 1'b1);
	endtask

	initial begin
		void'($urandom(10702));
		rst          = 1'b1;
		CPU_ADDR     = '0;
		CPU_DIN      = '0;
		CPU_BE       = '0;
		CPU_BURSTCNT = '0;
		CPU_RD       = 1'b0;
		CPU_WE       = 1'b0;
		reset_sweep();
		read_miss();
		read_hit();
		write_through();
		lru_replace();
		$display("Run finished after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+logic
logic/l2_cache_pkg.sv
logic/way_access_if.sv
logic/lru_if.sv
logic/cache_ways.sv
logic/lru_tracker.sv
logic/cache_controller.sv
logic/l2_cache.sv
dv/ddr_model.sv
dv/l2_cache_tb.sv

// ==== Bender.yml ====
package:
  name: l2_cache

export_include_dirs:
  - logic

sources:
  - files:
      - logic/l2_cache_pkg.sv
      - logic/way_access_if.sv
      - logic/lru_if.sv
      - logic/cache_ways.sv
      - logic/lru_tracker.sv
      - logic/cache_controller.sv
      - logic/l2_cache.sv
  - target: simulation
    files:
      - dv/ddr_model.sv
      - dv/l2_cache_tb.sv
